// File: hdl/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // instruction word, read as i-type or j-type
    // r-type rd lives at imm16[15:11], shamt at imm16[10:6]
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

    // one-hot alu select, top bit enables overflow trap
    typedef logic [12:0] alu_op_t;

    localparam int ALU_ADD      = 0;
    localparam int ALU_SUB      = 1;
    localparam int ALU_SLT      = 2;
    localparam int ALU_SLTU     = 3;
    localparam int ALU_AND      = 4;
    localparam int ALU_NOR      = 5;
    localparam int ALU_OR       = 6;
    localparam int ALU_XOR      = 7;
    localparam int ALU_SLL      = 8;
    localparam int ALU_SRL      = 9;
    localparam int ALU_SRA      = 10;
    localparam int ALU_LUI      = 11;
    localparam int ALU_OV_CHECK = 12;

    // one-hot branch and jump kind
    typedef logic [11:0] br_op_t;

    localparam int BR_BEQ    = 0;
    localparam int BR_BNE    = 1;
    localparam int BR_BGEZ   = 2;
    localparam int BR_BGTZ   = 3;
    localparam int BR_BLEZ   = 4;
    localparam int BR_BLTZ   = 5;
    localparam int BR_BGEZAL = 6;
    localparam int BR_BLTZAL = 7;
    localparam int BR_J      = 8;
    localparam int BR_JAL    = 9;
    localparam int BR_JR     = 10;
    localparam int BR_JALR   = 11;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

    // first alu source
    typedef logic [1:0] src1_sel_t;

    localparam src1_sel_t SRC1_RS    = 2'd0;
    localparam src1_sel_t SRC1_PC    = 2'd1;
    localparam src1_sel_t SRC1_SHAMT = 2'd2;

    // second alu source
    typedef logic [1:0] src2_sel_t;

    localparam src2_sel_t SRC2_RT     = 2'd0;
    localparam src2_sel_t SRC2_IMM_SE = 2'd1;
    localparam src2_sel_t SRC2_EIGHT  = 2'd2;
    localparam src2_sel_t SRC2_IMM_ZE = 2'd3;

    // one-hot memory access kind
    typedef logic [7:0] mem_op_t;

    localparam int MEM_LB  = 0;
    localparam int MEM_LBU = 1;
    localparam int MEM_LH  = 2;
    localparam int MEM_LHU = 3;
    localparam int MEM_LW  = 4;
    localparam int MEM_SB  = 5;
    localparam int MEM_SH  = 6;
    localparam int MEM_SW  = 7;

    // link address is pc plus two instructions
    localparam logic [31:0] LINK_OFFSET = 32'd8;

    localparam logic [3:0] LANE_ALL = 4'b1111;

endpackage

// File: hdl/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                stall_ex_i,
    input  logic                stall_mem_i,
    input  isa_pkg::word_t      pc_i,
    input  isa_pkg::word_t      rs_data_i,
    input  isa_pkg::word_t      rt_data_i,
    input  isa_pkg::instr_t     inst_i,
    input  isa_pkg::alu_op_t    alu_op_i,
    input  pipe_pkg::src1_sel_t sel_src1_i,
    input  pipe_pkg::src2_sel_t sel_src2_i,
    input  isa_pkg::br_op_t     br_op_i,
    input  pipe_pkg::mem_op_t   mem_op_i,
    input  logic                data_en_i,
    input  logic                rf_we_i,
    input  isa_pkg::reg_addr_t  rf_waddr_i,
    output isa_pkg::word_t      pc_o,
    output isa_pkg::word_t      rs_data_o,
    output isa_pkg::word_t      rt_data_o,
    output isa_pkg::instr_t     inst_o,
    output isa_pkg::alu_op_t    alu_op_o,
    output pipe_pkg::src1_sel_t sel_src1_o,
    output pipe_pkg::src2_sel_t sel_src2_o,
    output isa_pkg::br_op_t     br_op_o,
    output pipe_pkg::mem_op_t   mem_op_o,
    output logic                data_en_o,
    output logic                rf_we_o,
    output isa_pkg::reg_addr_t  rf_waddr_o,
    output logic                in_delay_slot_o
);

    logic bubble;
    logic load;

    // ex stalled while mem runs, so send a bubble downstream
    assign bubble = stall_ex_i & ~stall_mem_i;
    assign load   = ~stall_ex_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i || bubble) begin
            alu_op_o        <= '0;
            sel_src1_o      <= '0;
            sel_src2_o      <= '0;
            br_op_o         <= '0;
            mem_op_o        <= '0;
            data_en_o       <= 1'b0;
            rf_we_o         <= 1'b0;
            rf_waddr_o      <= '0;
            in_delay_slot_o <= 1'b0;
        end else if (load) begin
            alu_op_o        <= alu_op_i;
            sel_src1_o      <= sel_src1_i;
            sel_src2_o      <= sel_src2_i;
            br_op_o         <= br_op_i;
            mem_op_o        <= mem_op_i;
            data_en_o       <= data_en_i;
            rf_we_o         <= rf_we_i;
            rf_waddr_o      <= rf_waddr_i;
            // predecessor was a branch or jump
            in_delay_slot_o <= |br_op_o;
        end
    end

    // operands and instruction word
    always_ff @(posedge clk) begin
        if (flush_i || bubble) begin
            pc_o      <= '0;
            rs_data_o <= '0;
            rt_data_o <= '0;
            inst_o    <= '0;
        end else if (load) begin
            pc_o      <= pc_i;
            rs_data_o <= rs_data_i;
            rt_data_o <= rt_data_i;
            inst_o    <= inst_i;
        end
    end

endmodule

// File: hdl/ex_operand_sel.sv
`timescale 1ns/1ps

module ex_operand_sel (
    input  isa_pkg::word_t      rs_data_i,
    input  isa_pkg::word_t      rt_data_i,
    input  isa_pkg::word_t      rs_fwd_data_i,
    input  isa_pkg::word_t      rt_fwd_data_i,
    input  isa_pkg::word_t      pc_i,
    input  logic                rs_fwd_sel_i,
    input  logic                rt_fwd_sel_i,
    input  isa_pkg::instr_t     inst_i,
    input  pipe_pkg::src1_sel_t sel_src1_i,
    input  pipe_pkg::src2_sel_t sel_src2_i,
    output isa_pkg::word_t      rs_val_o,
    output isa_pkg::word_t      rt_val_o,
    output isa_pkg::word_t      src1_o,
    output isa_pkg::word_t      src2_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t imm_sext;
    word_t imm_zext;
    word_t shamt_zext;

    assign rs_val_o = rs_fwd_sel_i ? rs_fwd_data_i : rs_data_i;
    assign rt_val_o = rt_fwd_sel_i ? rt_fwd_data_i : rt_data_i;

    assign imm_sext   = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
    assign imm_zext   = {16'b0, inst_i.i.imm16};
    assign shamt_zext = {27'b0, inst_i.i.imm16[10:6]};

    always_comb begin
        case (sel_src1_i)
            SRC1_RS:    src1_o = rs_val_o;
            SRC1_PC:    src1_o = pc_i;
            SRC1_SHAMT: src1_o = shamt_zext;
            default:    src1_o = '0;
        endcase
    end

    always_comb begin
        case (sel_src2_i)
            SRC2_RT:     src2_o = rt_val_o;
            SRC2_IMM_SE: src2_o = imm_sext;
            SRC2_EIGHT:  src2_o = LINK_OFFSET;
            SRC2_IMM_ZE: src2_o = imm_zext;
        endcase
    end

endmodule

// File: hdl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  isa_pkg::alu_op_t alu_op_i,
    input  isa_pkg::word_t   src1_i,
    input  isa_pkg::word_t   src2_i,
    output isa_pkg::word_t   result_o,
    output logic             overflow_o
);
    import isa_pkg::*;

    word_t      sum;
    word_t      diff;
    word_t      slt_res;
    word_t      sltu_res;
    logic [4:0] sh;
    logic       add_ov;
    logic       sub_ov;

    assign sum  = src1_i + src2_i;
    assign diff = src1_i - src2_i;

    assign slt_res  = {31'b0, $signed(src1_i) < $signed(src2_i)};
    assign sltu_res = {31'b0, src1_i < src2_i};

    // shift amount comes from src1, value from src2
    assign sh = src1_i[4:0];

    assign result_o = ({32{alu_op_i[ALU_ADD]}}  & sum)
                    | ({32{alu_op_i[ALU_SUB]}}  & diff)
                    | ({32{alu_op_i[ALU_SLT]}}  & slt_res)
                    | ({32{alu_op_i[ALU_SLTU]}} & sltu_res)
                    | ({32{alu_op_i[ALU_AND]}}  & (src1_i & src2_i))
                    | ({32{alu_op_i[ALU_NOR]}}  & ~(src1_i | src2_i))
                    | ({32{alu_op_i[ALU_OR]}}   & (src1_i | src2_i))
                    | ({32{alu_op_i[ALU_XOR]}}  & (src1_i ^ src2_i))
                    | ({32{alu_op_i[ALU_SLL]}}  & (src2_i << sh))
                    | ({32{alu_op_i[ALU_SRL]}}  & (src2_i >> sh))
                    | ({32{alu_op_i[ALU_SRA]}}  & word_t'($signed(src2_i) >>> sh))
                    | ({32{alu_op_i[ALU_LUI]}}  & {src2_i[15:0], 16'b0});

    // same-sign operands, result sign flipped
    assign add_ov = (src1_i[31] == src2_i[31]) && (sum[31] != src1_i[31]);
    // opposite signs, result takes subtrahend sign
    assign sub_ov = (src1_i[31] != src2_i[31]) && (diff[31] != src1_i[31]);

    assign overflow_o = alu_op_i[ALU_OV_CHECK]
                      & ((alu_op_i[ALU_ADD] & add_ov) | (alu_op_i[ALU_SUB] & sub_ov));

endmodule

// File: hdl/ex_branch_resolve.sv
`timescale 1ns/1ps

module ex_branch_resolve (
    input  isa_pkg::br_op_t  br_op_i,
    input  isa_pkg::instr_t  inst_i,
    input  isa_pkg::word_t   pc_i,
    input  isa_pkg::word_t   rs_val_i,
    input  isa_pkg::word_t   rt_val_i,
    input  logic             bp_taken_i,
    input  isa_pkg::word_t   bp_target_i,
    output logic             redirect_o,
    output isa_pkg::word_t   redirect_target_o
);
    import isa_pkg::*;

    word_t pc_plus4;
    word_t pc_plus8;
    word_t br_offset;
    word_t real_target;
    logic  cond_br;
    logic  jump_abs;
    logic  jump_reg;
    logic  rs_eq_rt;
    logic  rs_zero;
    logic  rs_neg;
    logic  taken;
    logic  taken_err;
    logic  not_taken_err;

    assign pc_plus4  = pc_i + 32'd4;
    assign pc_plus8  = pc_i + 32'd8;
    assign br_offset = {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};

    assign cond_br  = |br_op_i[BR_BLTZAL:BR_BEQ];
    assign jump_abs = br_op_i[BR_J] | br_op_i[BR_JAL];
    assign jump_reg = br_op_i[BR_JR] | br_op_i[BR_JALR];

    assign rs_eq_rt = (rs_val_i == rt_val_i);
    assign rs_zero  = (rs_val_i == '0);
    assign rs_neg   = rs_val_i[31];

    assign taken = (br_op_i[BR_BEQ]    & rs_eq_rt)
                 | (br_op_i[BR_BNE]    & ~rs_eq_rt)
                 | (br_op_i[BR_BGEZ]   & ~rs_neg)
                 | (br_op_i[BR_BGEZAL] & ~rs_neg)
                 | (br_op_i[BR_BGTZ]   & ~rs_neg & ~rs_zero)
                 | (br_op_i[BR_BLEZ]   & (rs_neg | rs_zero))
                 | (br_op_i[BR_BLTZ]   & rs_neg)
                 | (br_op_i[BR_BLTZAL] & rs_neg)
                 | jump_abs
                 | jump_reg;

    always_comb begin
        if (cond_br) begin
            real_target = pc_plus4 + br_offset;
        end else if (jump_abs) begin
            real_target = {pc_plus4[31:28], inst_i.j.target26, 2'b00};
        end else if (jump_reg) begin
            real_target = rs_val_i;
        end else begin
            real_target = '0;
        end
    end

    // missed or wrong-target prediction vs. false taken prediction
    assign taken_err     = taken & (~bp_taken_i | (real_target != bp_target_i));
    assign not_taken_err = bp_taken_i & ~taken;

    assign redirect_o        = taken_err | not_taken_err;
    assign redirect_target_o = taken_err     ? real_target :
                               not_taken_err ? pc_plus8 : '0;

endmodule

// File: hdl/ex_mem_request.sv
`timescale 1ns/1ps

module ex_mem_request (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush_i,
    input  pipe_pkg::mem_op_t mem_op_i,
    input  logic              data_en_i,
    input  isa_pkg::word_t    addr_i,
    input  isa_pkg::word_t    rt_val_i,
    input  logic              overflow_i,
    output logic              data_en_o,
    output logic              data_we_o,
    output logic [3:0]        data_sel_o,
    output isa_pkg::word_t    data_addr_o,
    output isa_pkg::word_t    data_wdata_o,
    output logic              load_misalign_o,
    output logic              store_misalign_o,
    output isa_pkg::word_t    bad_vaddr_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic       is_store;
    logic [1:0] offs;
    logic       exc;
    logic       squash;

    assign offs = addr_i[1:0];

    assign is_byte  = mem_op_i[MEM_LB] | mem_op_i[MEM_LBU] | mem_op_i[MEM_SB];
    assign is_half  = mem_op_i[MEM_LH] | mem_op_i[MEM_LHU] | mem_op_i[MEM_SH];
    assign is_word  = mem_op_i[MEM_LW] | mem_op_i[MEM_SW];
    assign is_store = mem_op_i[MEM_SB] | mem_op_i[MEM_SH] | mem_op_i[MEM_SW];

    assign load_misalign_o  = ((mem_op_i[MEM_LH] | mem_op_i[MEM_LHU]) & offs[0])
                            | (mem_op_i[MEM_LW] & (|offs));
    assign store_misalign_o = (mem_op_i[MEM_SH] & offs[0])
                            | (mem_op_i[MEM_SW] & (|offs));

    assign exc = load_misalign_o | store_misalign_o | overflow_i;

    always_comb begin
        data_sel_o   = '0;
        data_wdata_o = '0;
        if (is_byte) begin
            data_sel_o   = 4'b0001 << offs;
            data_wdata_o = {4{rt_val_i[7:0]}};
        end else if (is_half) begin
            // odd address gets no lanes
            if (!offs[0]) begin
                data_sel_o = offs[1] ? 4'b1100 : 4'b0011;
            end
            data_wdata_o = {2{rt_val_i[15:0]}};
        end else if (is_word) begin
            data_sel_o   = LANE_ALL;
            data_wdata_o = rt_val_i;
        end
        if (!is_store) begin
            data_wdata_o = '0;
        end
    end

    // after an exception no later access reaches memory until flush
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            squash <= 1'b0;
        end else if (exc) begin
            squash <= 1'b1;
        end
    end

    assign data_en_o   = data_en_i & ~squash & ~exc;
    assign data_we_o   = is_store;
    assign data_addr_o = addr_i;
    assign bad_vaddr_o = addr_i;

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                stall_ex_i,
    input  logic                stall_mem_i,
    input  isa_pkg::word_t      pc_i,
    input  isa_pkg::word_t      rs_data_i,
    input  isa_pkg::word_t      rt_data_i,
    input  isa_pkg::instr_t     inst_i,
    input  isa_pkg::alu_op_t    alu_op_i,
    input  pipe_pkg::src1_sel_t sel_src1_i,
    input  pipe_pkg::src2_sel_t sel_src2_i,
    input  isa_pkg::br_op_t     br_op_i,
    input  pipe_pkg::mem_op_t   mem_op_i,
    input  logic                data_en_i,
    input  logic                rf_we_i,
    input  isa_pkg::reg_addr_t  rf_waddr_i,
    input  logic                rs_fwd_sel_i,
    input  isa_pkg::word_t      rs_fwd_data_i,
    input  logic                rt_fwd_sel_i,
    input  isa_pkg::word_t      rt_fwd_data_i,
    input  logic                bp_taken_i,
    input  isa_pkg::word_t      bp_target_i,
    output isa_pkg::word_t      result_o,
    output logic                rf_we_o,
    output isa_pkg::reg_addr_t  rf_waddr_o,
    output isa_pkg::word_t      pc_o,
    output pipe_pkg::mem_op_t   mem_op_o,
    output logic                overflow_o,
    output logic                in_delay_slot_o,
    output logic                redirect_o,
    output isa_pkg::word_t      redirect_target_o,
    output logic                data_en_o,
    output logic                data_we_o,
    output logic [3:0]          data_sel_o,
    output isa_pkg::word_t      data_addr_o,
    output isa_pkg::word_t      data_wdata_o,
    output logic                load_misalign_o,
    output logic                store_misalign_o,
    output isa_pkg::word_t      bad_vaddr_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // registered decode fields
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    instr_t    ex_inst;
    alu_op_t   ex_alu_op;
    src1_sel_t ex_sel_src1;
    src2_sel_t ex_sel_src2;
    br_op_t    ex_br_op;
    logic      ex_data_en;

    word_t rs_val;
    word_t rt_val;
    word_t src1;
    word_t src2;

    ex_stage_reg u_reg (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .stall_ex_i      (stall_ex_i),
        .stall_mem_i     (stall_mem_i),
        .pc_i            (pc_i),
        .rs_data_i       (rs_data_i),
        .rt_data_i       (rt_data_i),
        .inst_i          (inst_i),
        .alu_op_i        (alu_op_i),
        .sel_src1_i      (sel_src1_i),
        .sel_src2_i      (sel_src2_i),
        .br_op_i         (br_op_i),
        .mem_op_i        (mem_op_i),
        .data_en_i       (data_en_i),
        .rf_we_i         (rf_we_i),
        .rf_waddr_i      (rf_waddr_i),
        .pc_o            (pc_o),
        .rs_data_o       (ex_rs_data),
        .rt_data_o       (ex_rt_data),
        .inst_o          (ex_inst),
        .alu_op_o        (ex_alu_op),
        .sel_src1_o      (ex_sel_src1),
        .sel_src2_o      (ex_sel_src2),
        .br_op_o         (ex_br_op),
        .mem_op_o        (mem_op_o),
        .data_en_o       (ex_data_en),
        .rf_we_o         (rf_we_o),
        .rf_waddr_o      (rf_waddr_o),
        .in_delay_slot_o (in_delay_slot_o)
    );

    ex_operand_sel u_opsel (
        .rs_data_i     (ex_rs_data),
        .rt_data_i     (ex_rt_data),
        .rs_fwd_data_i (rs_fwd_data_i),
        .rt_fwd_data_i (rt_fwd_data_i),
        .pc_i          (pc_o),
        .rs_fwd_sel_i  (rs_fwd_sel_i),
        .rt_fwd_sel_i  (rt_fwd_sel_i),
        .inst_i        (ex_inst),
        .sel_src1_i    (ex_sel_src1),
        .sel_src2_i    (ex_sel_src2),
        .rs_val_o      (rs_val),
        .rt_val_o      (rt_val),
        .src1_o        (src1),
        .src2_o        (src2)
    );

    ex_alu u_alu (
        .alu_op_i   (ex_alu_op),
        .src1_i     (src1),
        .src2_i     (src2),
        .result_o   (result_o),
        .overflow_o (overflow_o)
    );

    ex_branch_resolve u_branch (
        .br_op_i           (ex_br_op),
        .inst_i            (ex_inst),
        .pc_i              (pc_o),
        .rs_val_i          (rs_val),
        .rt_val_i          (rt_val),
        .bp_taken_i        (bp_taken_i),
        .bp_target_i       (bp_target_i),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

    // alu result doubles as the data address
    ex_mem_request u_mem (
        .clk              (clk),
        .rst              (rst),
        .flush_i          (flush_i),
        .mem_op_i         (mem_op_o),
        .data_en_i        (ex_data_en),
        .addr_i           (result_o),
        .rt_val_i         (rt_val),
        .overflow_i       (overflow_o),
        .data_en_o        (data_en_o),
        .data_we_o        (data_we_o),
        .data_sel_o       (data_sel_o),
        .data_addr_o      (data_addr_o),
        .data_wdata_o     (data_wdata_o),
        .load_misalign_o  (load_misalign_o),
        .store_misalign_o (store_misalign_o),
        .bad_vaddr_o      (bad_vaddr_o)
    );

endmodule

// File: tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    logic        clk;
    logic        rst;
    logic        flush_i;
    logic        stall_ex_i;
    logic        stall_mem_i;
    logic [31:0] pc_i;
    logic [31:0] rs_data_i;
    logic [31:0] rt_data_i;
    logic [31:0] inst_i;
    logic [12:0] alu_op_i;
    logic [1:0]  sel_src1_i;
    logic [1:0]  sel_src2_i;
    logic [11:0] br_op_i;
    logic [7:0]  mem_op_i;
    logic        data_en_i;
    logic        rf_we_i;
    logic [4:0]  rf_waddr_i;
    logic        rs_fwd_sel_i;
    logic [31:0] rs_fwd_data_i;
    logic        rt_fwd_sel_i;
    logic [31:0] rt_fwd_data_i;
    logic        bp_taken_i;
    logic [31:0] bp_target_i;

    logic [31:0] result_o;
    logic        rf_we_o;
    logic [4:0]  rf_waddr_o;
    logic [31:0] pc_o;
    logic [7:0]  mem_op_o;
    logic        overflow_o;
    logic        in_delay_slot_o;
    logic        redirect_o;
    logic [31:0] redirect_target_o;
    logic        data_en_o;
    logic        data_we_o;
    logic [3:0]  data_sel_o;
    logic [31:0] data_addr_o;
    logic [31:0] data_wdata_o;
    logic        load_misalign_o;
    logic        store_misalign_o;
    logic [31:0] bad_vaddr_o;

    // one row per cycle, twenty hex columns
    logic [31:0] trace [0:127][0:19];
    logic [31:0] fields [0:19];
    int          num_lines;
    string       flag_names [0:6];

    // expected contents of the pipeline register
    logic [31:0] exp_pc;
    logic [4:0]  exp_waddr;
    logic [7:0]  exp_mem_op;

    ex_stage uut (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, exp_v, act_v);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_line(input int n);
        logic [31:0] ctl;
        ctl           = trace[n][0];
        flush_i       = ctl[0];
        stall_ex_i    = ctl[1];
        stall_mem_i   = ctl[2];
        data_en_i     = ctl[3];
        rf_we_i       = ctl[4];
        rs_fwd_sel_i  = ctl[5];
        rt_fwd_sel_i  = ctl[6];
        bp_taken_i    = ctl[7];
        pc_i          = trace[n][1];
        rs_data_i     = trace[n][2];
        rt_data_i     = trace[n][3];
        inst_i        = trace[n][4];
        alu_op_i      = trace[n][5][12:0];
        sel_src1_i    = trace[n][6][1:0];
        sel_src2_i    = trace[n][7][1:0];
        br_op_i       = trace[n][8][11:0];
        mem_op_i      = trace[n][9][7:0];
        rf_waddr_i    = trace[n][10][4:0];
        rs_fwd_data_i = trace[n][11];
        rt_fwd_data_i = trace[n][12];
        bp_target_i   = trace[n][13];
    endtask

    // flush first, then bubble, then load, otherwise hold
    task automatic track_register(input int n);
        logic [31:0] ctl;
        ctl = trace[n][0];
        if (ctl[0] || (ctl[1] && !ctl[2])) begin
            exp_pc     = '0;
            exp_waddr  = '0;
            exp_mem_op = '0;
        end else if (!ctl[1]) begin
            exp_pc     = trace[n][1];
            exp_waddr  = trace[n][10][4:0];
            exp_mem_op = trace[n][9][7:0];
        end
    endtask

    task automatic compare_line(input int n);
        logic [31:0] mask;
        logic [6:0]  exp_flags;
        logic [6:0]  act_flags;
        mask      = trace[n][14];
        exp_flags = trace[n][19][6:0];
        act_flags = {rf_we_o, in_delay_slot_o, store_misalign_o, load_misalign_o,
                     data_en_o, redirect_o, overflow_o};
        for (int b = 0; b < 7; b++) begin
            if (mask[b]) begin
                check_value(flag_names[b], {31'b0, exp_flags[b]}, {31'b0, act_flags[b]});
            end
        end
        if (mask[8]) begin
            check_value("result_o", trace[n][15], result_o);
            check_value("data_addr_o", trace[n][15], data_addr_o);
            check_value("pc_o", exp_pc, pc_o);
            check_value("rf_waddr_o", {27'b0, exp_waddr}, {27'b0, rf_waddr_o});
            check_value("mem_op_o", {24'b0, exp_mem_op}, {24'b0, mem_op_o});
            // sb, sh and sw write
            check_value("data_we_o", {31'b0, |exp_mem_op[7:5]}, {31'b0, data_we_o});
        end
        if (mask[9]) check_value("redirect_target_o", trace[n][16], redirect_target_o);
        if (mask[10]) check_value("data_sel_o", trace[n][17], {28'b0, data_sel_o});
        if (mask[11]) check_value("data_wdata_o", trace[n][18], data_wdata_o);
        // bad address always follows the alu result
        if (mask[12]) check_value("bad_vaddr_o", trace[n][15], bad_vaddr_o);
    endtask

    task automatic load_trace();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("tests/ex_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tests/ex_trace.txt");
            $display("TEST FAILED");
            $fatal(1, "no trace");
        end
        num_lines = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              fields[0], fields[1], fields[2], fields[3], fields[4],
                              fields[5], fields[6], fields[7], fields[8], fields[9],
                              fields[10], fields[11], fields[12], fields[13], fields[14],
                              fields[15], fields[16], fields[17], fields[18], fields[19]);
                if (cnt == 20) begin
                    for (int k = 0; k < 20; k++) begin
                        trace[num_lines][k] = fields[k];
                    end
                    num_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        flush_i       = 1'b0;
        stall_ex_i    = 1'b0;
        stall_mem_i   = 1'b0;
        pc_i          = '0;
        rs_data_i     = '0;
        rt_data_i     = '0;
        inst_i        = '0;
        alu_op_i      = '0;
        sel_src1_i    = '0;
        sel_src2_i    = '0;
        br_op_i       = '0;
        mem_op_i      = '0;
        data_en_i     = 1'b0;
        rf_we_i       = 1'b0;
        rf_waddr_i    = '0;
        rs_fwd_sel_i  = 1'b0;
        rs_fwd_data_i = '0;
        rt_fwd_sel_i  = 1'b0;
        rt_fwd_data_i = '0;
        bp_taken_i    = 1'b0;
        bp_target_i   = '0;
        exp_pc        = '0;
        exp_waddr     = '0;
        exp_mem_op    = '0;
        flag_names[0] = "overflow_o";
        flag_names[1] = "redirect_o";
        flag_names[2] = "data_en_o";
        flag_names[3] = "load_misalign_o";
        flag_names[4] = "store_misalign_o";
        flag_names[5] = "in_delay_slot_o";
        flag_names[6] = "rf_we_o";

        load_trace();
        repeat (8) @(posedge clk);
        for (int n = 0; n < num_lines; n++) begin
            #1;
            rst = 1'b0;
            apply_line(n);
            // sample just before the next edge
            #8;
            compare_line(n);
            @(posedge clk);
            track_register(n);
        end
        $display("TEST OK");
        $finish;
    end

    // watchdog
    initial begin
        #1;
        #((num_lines + 20) * 10);
        $display("simulation ran past its time limit");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: sources.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/ex_stage_reg.sv
hdl/ex_operand_sel.sv
hdl/ex_alu.sv
hdl/ex_branch_resolve.sv
hdl/ex_mem_request.sv
hdl/ex_stage.sv
tests/tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_ex_stage -o sim_ex_stage

out=$(./obj_dir/sim_ex_stage)
echo "$out"

# success only when the pass line shows up
echo "$out" | grep -q "TEST OK"

// File: tests/ex_trace.txt
# ctl pc rs rt inst alu s1 s2 br mem wa rsf rtf bptgt | mask res rtgt sel wdata flags
# decode fields enter ex at the next edge; fwd, bp and expected values refer to the ex instruction
10 0 5 3 0 1 0 0 0 0 1 0 0 0 7F 0 0 0 0 0
10 0 5 7 0 2 0 0 0 0 1 0 0 0 17F 8 0 0 0 40
10 0 FFFFFFFF 1 0 4 0 0 0 0 1 0 0 0 17F FFFFFFFE 0 0 0 40
10 0 FFFFFFFF 1 0 8 0 0 0 0 1 0 0 0 17F 1 0 0 0 40
10 0 F0F0FFFF 0FF00F0F 0 10 0 0 0 0 1 0 0 0 17F 0 0 0 0 40
10 0 F0F00000 000F0000 0 20 0 0 0 0 1 0 0 0 17F 00F00F0F 0 0 0 40
10 0 12340000 0 8001 40 0 3 0 0 1 0 0 0 17F 0F00FFFF 0 0 0 40
10 0 FFFF 0 8001 80 0 1 0 0 1 0 0 0 17F 12348001 0 0 0 40
10 0 0 F 100 100 2 0 0 0 1 0 0 0 17F FFFF7FFE 0 0 0 40
10 0 0 80000000 100 200 2 0 0 0 1 0 0 0 17F F0 0 0 0 40
10 0 0 80000000 100 400 2 0 0 0 1 0 0 0 17F 08000000 0 0 0 40
10 0 0 0 1234 800 0 3 0 0 1 0 0 0 17F F8000000 0 0 0 40
10 400010 0 0 0 1 1 2 0 0 1 0 0 0 17F 12340000 0 0 0 40
10 0 7FFFFFFF 1 0 1001 0 0 0 0 1 0 0 0 17F 400018 0 0 0 40
10 0 7FFFFFFF 1 0 1 0 0 0 0 1 0 0 0 17F 80000000 0 0 0 41
01 0 0 0 0 0 0 0 0 0 0 0 0 0 17F 80000000 0 0 0 40
10 0 1 2 0 1 0 0 0 0 1 0 0 0 17F 0 0 0 0 0
20 1000 5 9 4 0 0 0 1 0 0 100 0 0 17F 102 0 0 0 40
D0 0 1 1 0 1 0 0 0 0 1 0 5 1014 7F 0 0 0 0 0
00 2000 1 2 FFFC 0 0 0 2 0 0 0 0 0 17F 2 0 0 0 60
00 10000000 0 0 08000040 0 0 0 100 0 0 0 0 0 27F 0 1FF4 0 0 02
80 3000 0 0 0 0 0 0 8 0 0 0 0 10000200 27F 0 10000100 0 0 22
80 0 4444 0 0 0 0 0 400 0 0 0 0 3010 27F 0 3008 0 0 22
88 0 101 AB 0 1 0 1 0 20 0 0 0 4444 7F 0 0 0 0 20
08 0 102 BEEF 0 1 0 1 0 40 0 0 0 0 1D7F 101 0 2 ABABABAB 24
08 0 200 DEADBEEF 0 1 0 1 0 80 0 0 0 0 1D7F 102 0 C BEEFBEEF 04
08 0 103 FFFFFFFF 0 1 0 1 0 1 0 0 0 0 1D7F 200 0 F DEADBEEF 04
08 0 100 0 0 1 0 1 0 8 0 0 0 0 1D7F 103 0 8 0 04
08 0 101 0 0 1 0 1 0 4 0 0 0 0 1D7F 100 0 3 0 04
08 0 204 0 0 1 0 1 0 10 0 0 0 0 1D7F 101 0 0 0 08
08 0 206 11223344 0 1 0 1 0 80 0 0 0 0 1D7F 204 0 F 0 00
01 0 0 0 0 0 0 0 0 0 0 0 0 0 1D7F 206 0 F 11223344 10
08 0 204 0 0 1 0 1 0 10 0 0 0 0 1D7F 0 0 0 0 00
10 0 10 20 0 1 0 0 0 0 1 0 0 0 1D7F 204 0 F 0 04
16 0 1 1 0 1 0 0 0 0 1 0 0 0 17F 30 0 0 0 40
12 0 1 1 0 1 0 0 0 0 1 0 0 0 17F 30 0 0 0 40
00 0 0 0 0 0 0 0 0 0 0 0 0 0 17F 0 0 0 0 00
00 0 0 0 0 0 0 0 0 0 0 0 0 0 17F 0 0 0 0 00
